//--- vlog.f
common/cpu_pkg.sv
common/bus_pkg.sv
common/wb_if.sv
design/alu/alu.sv
design/core/cpu_core.sv
design/wb_arbiter.sv
design/wb_ram.sv
design/cpu_top.sv
verification/cpu_props.sv
verification/tb_cpu.sv

//--- Bender.yml
package:
  name: cpu_top

sources:
  - files:
      - common/cpu_pkg.sv
      - common/bus_pkg.sv
      - common/wb_if.sv
      - design/alu/alu.sv
      - design/core/cpu_core.sv
      - design/wb_arbiter.sv
      - design/wb_ram.sv
      - design/cpu_top.sv
  - target: test
    files:
      - verification/cpu_props.sv
      - verification/tb_cpu.sv

//--- verification/tb_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu;
   import cpu_pkg::*;
   import bus_pkg::*;

   localparam logic [7:0] spin_adr = 8'h90; // never written by any program

   logic        clk;
   logic        rst;
   logic        start;
   logic        halted;
   logic        host_cyc;
   logic        host_stb;
   logic        host_we;
   logic [7:0]  host_adr;
   logic [31:0] host_dat_w;
   logic [31:0] host_dat_r;
   logic        host_ack;

   logic [31:0] seed = 32'h5da7;
   logic [31:0] ref_regs [16];
   logic [7:0]  ref_flags;
   logic [31:0] ref_mem [ram_depth];
   logic [31:0] prog [$];
   logic [7:0]  seen_adr [$];
   logic [31:0] seen_dat [$];
   int          errors = 0;
   int          cycles = 0;
   int          limit = 20; // grows with every transfer and program

   cpu_top dut0 (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .halted     (halted),
      .host_cyc   (host_cyc),
      .host_stb   (host_stb),
      .host_we    (host_we),
      .host_adr   (host_adr),
      .host_dat_w (host_dat_w),
      .host_dat_r (host_dat_r),
      .host_ack   (host_ack)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("Timeout after %0d cycles waiting for halted or host_ack", cycles);
         $display("Errors: %0d", errors);
         $display("Finished with errors");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      seed = xorshift(seed);
      return seed;
   endfunction

   function automatic logic [31:0] make_insn(input logic [5:0] op, input logic [3:0] rd,
                                             input logic [3:0] rb, input logic [15:0] im);
      return {op, rd, rb, 2'b00, im};
   endfunction

   function automatic logic [31:0] rand_insn(input logic [1:0] cls);
      logic [31:0] r;
      logic [5:0]  op;
      r  = next_rand();
      op = (cls == 2'b10) ? 6'h20 + 6'(r[3:0] % 11) : {cls, r[3:0]}; // no getf here
      return make_insn(op, r[7:4], r[11:8], r[31:16]);
   endfunction

   // one instruction on the shadow state, returns 1 on halt
   function automatic bit exec_ref(input logic [31:0] w);
      logic [5:0]  op;
      logic [5:0]  base;
      logic [3:0]  rd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      logic [32:0] s;
      logic        cf;
      logic        add_grp;
      logic        log_grp;
      logic        sh_grp;
      op = w[31:26];
      rd = w[25:22];
      a  = ref_regs[rd];
      b  = ref_regs[w[21:18]];
      cf = ref_flags[flag_c];
      if (op[5:4] == 2'b01) begin
         case (op)
            op_testi: b = {16'hffff, w[15:0]};
            op_mvl, op_mvh, op_mvzl, op_mvs, op_andi, op_ori, op_xori:
               b = {16'h0000, w[15:0]};
            default:  b = {{16{w[15]}}, w[15:0]};
         endcase
      end
      base    = (op[5:4] == 2'b01 && op[3:2] != 2'b00) ? {2'b00, op[3:0]} : op;
      add_grp = base inside {op_add, op_adc, op_sub, op_sbb, op_cmp, op_plus};
      log_grp = base inside {op_and, op_or, op_xor, op_btst, op_test};
      sh_grp  = base inside {op_ror, op_rol, op_shl, op_shr, op_sha};
      if (base inside {op_sub, op_sbb, op_cmp})
         b = ~b;
      r = a;
      s = '0;
      case (base)
         op_add, op_plus:          s = a + b;
         op_adc, op_sbb:           s = a + b + cf;
         op_sub, op_cmp:           s = a + b + 1;
         op_ror:                   s = {a[0], cf, a[31:1]}; // bit 32 is carry out
         op_rol:                   s = {a, cf};
         op_shl:                   s = {a, 1'b0};
         op_shr:                   s = {a[0], 1'b0, a[31:1]};
         op_sha:                   s = {a[0], a[31], a[31:1]};
         op_mov:                   r = b;
         op_movl, op_mvl:          r = {a[31:16], b[15:0]};
         op_movh, op_mvh:          r = {b[15:0], a[15:0]};
         op_sed, op_mvs:           r = {{16{b[15]}}, b[15:0]};
         op_mvzl:                  r = {16'h0000, b[15:0]};
         op_mul:                   r = a * b;
         op_and, op_btst, op_test: r = a & b;
         op_or:                    r = a | b;
         op_xor:                   r = a ^ b;
         op_zeb:                   r = {24'h0, a[7:0]};
         op_zew:                   r = {16'h0, a[15:0]};
         op_seb:                   r = {{24{a[7]}}, a[7:0]};
         op_sew:                   r = {{16{a[15]}}, a[15:0]};
         op_not:                   r = ~a;
         op_neg:                   r = 32'h0 - a;
         op_getf:                  r = {24'h0, ref_flags};
         op_ld:                    ref_regs[rd] = ref_mem[w[7:0]];
         op_st:                    ref_mem[w[7:0]] = a;
         op_halt:                  return 1'b1;
         default: ;
      endcase
      if (add_grp || sh_grp)
         r = s[31:0];
      if (add_grp || sh_grp || log_grp) begin
         ref_flags[flag_z] = (r == 32'h0);
         ref_flags[flag_s] = r[31];
      end
      if (add_grp || sh_grp) begin
         ref_flags[flag_c] = s[32];
         ref_flags[flag_v] = add_grp ? (a[31] == b[31] && r[31] != a[31]) : (r[31] != a[31]);
      end
      if (op[5:4] != 2'b11 && !(base inside {op_cmp, op_btst, op_test}))
         ref_regs[rd] = r;
      return 1'b0;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic bus_xfer(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
      limit += 20;
      @(negedge clk);
      host_cyc   = 1'b1;
      host_stb   = 1'b1;
      host_we    = we;
      host_adr   = adr;
      host_dat_w = wdat;
      do
         @(negedge clk);
      while (!host_ack);
      rdat = host_dat_r;
      @(negedge clk); // held through the ack cycle
      host_cyc = 1'b0;
      host_stb = 1'b0;
      host_we  = 1'b0;
   endtask

   task automatic host_write(input logic [7:0] adr, input logic [31:0] dat);
      logic [31:0] unused;
      bus_xfer(1'b1, adr, dat, unused);
      ref_mem[adr] = dat;
   endtask

   task automatic host_read(input logic [7:0] adr);
      logic [31:0] dat;
      bus_xfer(1'b0, adr, 32'h0, dat);
      seen_adr.push_back(adr);
      seen_dat.push_back(dat);
   endtask

   task automatic reset_core();
      limit += 10;
      @(negedge clk);
      rst = 1'b1;
      repeat (3) @(negedge clk);
      rst = 1'b0;
   endtask

   task automatic init_regs();
      logic [31:0] r;
      for (int i = 0; i < 16; i++) begin
         r = next_rand();
         prog.push_back(make_insn(op_mvzl, 4'(i), 4'h0, r[15:0]));
         prog.push_back(make_insn(op_mvh, 4'(i), 4'h0, r[31:16]));
      end
   endtask

   task automatic store_regs();
      for (int i = 0; i < 16; i++)
         prog.push_back(make_insn(op_st, 4'(i), 4'h0, 16'h00c0 + 16'(i)));
      prog.push_back(make_insn(op_getf, 4'h0, 4'h0, 16'h0));
      prog.push_back(make_insn(op_st, 4'h0, 4'h0, 16'h00d0));
      prog.push_back(make_insn(op_halt, 4'h0, 4'h0, 16'h0));
   endtask

   task automatic run_program(input bit contend);
      int  pc;
      int  spins;
      bit  done;
      for (int i = 0; i < prog.size(); i++)
         host_write(8'(i), prog[i]);
      reset_core();
      limit += 50 * prog.size();
      @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      spins = 0;
      while (contend && !halted && spins < 40) begin
         host_read(spin_adr);
         spins++;
      end
      wait (halted);
      ref_flags = '0;
      pc   = 0;
      done = 1'b0;
      while (!done && pc < ram_depth) begin
         done = exec_ref(ref_mem[pc]);
         pc++;
      end
      for (int a = 0; a < ram_depth; a++)
         host_read(8'(a));
      prog.delete();
   endtask

   task automatic ld_st_program(input bit contend);
      logic [31:0] r;
      for (int i = 0; i < 8; i++)
         host_write(8'h80 + 8'(i), next_rand());
      init_regs();
      for (int i = 0; i < 8; i++) begin
         r = next_rand();
         prog.push_back(make_insn(op_ld, 4'(i), 4'h0, 16'h0080 + 16'(i)));
         prog.push_back(make_insn({2'b00, r[3:0]}, 4'(i), r[7:4], r[31:16]));
         prog.push_back(make_insn(op_st, 4'(i), 4'h0, 16'h00a0 + 16'(i)));
      end
      store_regs();
      run_program(contend);
   endtask

   initial begin : compare_reads
      logic [7:0]  a;
      logic [31:0] d;
      forever begin
         wait (seen_adr.size() != 0);
         a = seen_adr.pop_front();
         d = seen_dat.pop_front();
         check($sformatf("mem[%0d]", a), d, ref_mem[a]);
      end
   end

   initial begin : main
      logic [31:0] w;
      int          afails;
      clk        = 1'b0;
      rst        = 1'b1;
      start      = 1'b0;
      host_cyc   = 1'b0;
      host_stb   = 1'b0;
      host_we    = 1'b0;
      host_adr   = '0;
      host_dat_w = '0;
      repeat (3) @(negedge clk);
      rst = 1'b0;
      check("halted", {31'h0, halted}, 32'h0);
      check("host_ack", {31'h0, host_ack}, 32'h0);

      for (int a = 0; a < ram_depth; a++)
         host_write(8'(a), next_rand());
      for (int a = 0; a < ram_depth; a++)
         host_read(8'(a));

      init_regs(); // two-register class
      repeat (24) prog.push_back(rand_insn(2'b00));
      store_regs();
      run_program(1'b0);

      init_regs(); // immediate class
      repeat (24) prog.push_back(rand_insn(2'b01));
      store_regs();
      run_program(1'b0);

      init_regs(); // single operand, flags after each op
      for (int k = 0; k < 12; k++) begin
         w = rand_insn(2'b10);
         prog.push_back(w);
         prog.push_back(make_insn(op_getf, w[25:22] ^ 4'h1, 4'h0, 16'h0));
         prog.push_back(make_insn(op_st, w[25:22] ^ 4'h1, 4'h0, 16'h00e0 + 16'(k)));
         prog.push_back(make_insn(op_st, w[25:22], 4'h0, 16'h00f0 + 16'(k)));
      end
      store_regs();
      run_program(1'b0);

      ld_st_program(1'b0);
      ld_st_program(1'b1); // host polls spin_adr meanwhile

      wait (seen_adr.size() == 0);
      @(negedge clk);
      afails = dut0.arb0.arb_props.fails + dut0.ram0.ram_props.fails;
      $display("Errors: %0d, assertion failures: %0d", errors, afails);
      if (errors == 0 && afails == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- verification/cpu_props.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_props (
   input logic clk,
   input logic rst,
   input logic cyc,
   input logic stb,
   input logic ack,
   input logic gnt,
   input logic gnt_busy
);

   int fails = 0;

   ack_in_cycle: assert property (@(posedge clk) disable iff (rst) ack |-> cyc && stb)
      else begin
         fails++;
         $error("ack seen without cyc and stb");
      end

   ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
      else begin
         fails++;
         $error("ack high two cycles in a row");
      end

   // owner keeps the port for its whole cycle
   gnt_held: assert property (@(posedge clk) disable iff (rst) gnt_busy |=> $stable(gnt))
      else begin
         fails++;
         $error("grant changed while owner cyc was high");
      end

   stb_held: assert property (@(posedge clk) disable iff (rst) stb && !ack |=> stb)
      else begin
         fails++;
         $error("stb dropped before ack");
      end

endmodule

bind wb_ram cpu_props ram_props (
   .clk      (clk),
   .rst      (rst),
   .cyc      (bus.cyc),
   .stb      (bus.stb),
   .ack      (bus.ack),
   .gnt      (1'b0),
   .gnt_busy (1'b0)
);

bind wb_arbiter cpu_props arb_props (
   .clk      (clk),
   .rst      (rst),
   .cyc      (core.cyc),
   .stb      (core.stb),
   .ack      (core.ack),
   .gnt      (owner),
   .gnt_busy (ram.cyc)
);

`default_nettype wire

//--- design/cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           start,
   output logic                           halted,
   input  logic                           host_cyc,
   input  logic                           host_stb,
   input  logic                           host_we,
   input  logic [bus_pkg::adr_width-1:0]  host_adr,
   input  logic [cpu_pkg::data_width-1:0] host_dat_w,
   output logic [cpu_pkg::data_width-1:0] host_dat_r,
   output logic                           host_ack
);

   wb_if core_bus ();
   wb_if host_bus ();
   wb_if ram_bus ();

   assign host_bus.cyc   = host_cyc;
   assign host_bus.stb   = host_stb;
   assign host_bus.we    = host_we;
   assign host_bus.adr   = host_adr;
   assign host_bus.dat_w = host_dat_w;
   assign host_dat_r     = host_bus.dat_r;
   assign host_ack       = host_bus.ack;

   cpu_core core0 (
      .clk    (clk),
      .rst    (rst),
      .start  (start),
      .halted (halted),
      .bus    (core_bus.master)
   );

   wb_arbiter arb0 (
      .clk  (clk),
      .rst  (rst),
      .core (core_bus.slave),
      .host (host_bus.slave),
      .ram  (ram_bus.master)
   );

   wb_ram ram0 (
      .clk (clk),
      .rst (rst),
      .bus (ram_bus.slave)
   );

endmodule

`default_nettype wire

//--- design/wb_ram.sv
`timescale 1ns/100ps
`default_nettype none

module wb_ram (
   input  logic clk,
   input  logic rst,
   wb_if.slave  bus
);
   import cpu_pkg::*;
   import bus_pkg::*;

   logic [data_width-1:0] mem [ram_depth];
   logic                  req;

   // no new request in the ack cycle
   assign req = bus.cyc & bus.stb & ~bus.ack;

   always_ff @(posedge clk) begin
      if (rst)
         bus.ack <= 1'b0;
      else
         bus.ack <= req;
   end

   always_ff @(posedge clk) begin
      if (req && bus.we)
         mem[bus.adr] <= bus.dat_w;
      bus.dat_r <= mem[bus.adr]; // valid with ack
   end

endmodule

`default_nettype wire

//--- design/wb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module wb_arbiter (
   input  logic clk,
   input  logic rst,
   wb_if.slave  core,
   wb_if.slave  host,
   wb_if.master ram
);
   import bus_pkg::*;

   grant_e owner;
   grant_e other;
   logic   active;
   logic   sel_core;
   logic   own_cyc;
   logic   oth_cyc;
   logic   pass;

   assign sel_core = (owner == gnt_core);
   assign own_cyc  = sel_core ? core.cyc : host.cyc;
   assign oth_cyc  = sel_core ? host.cyc : core.cyc;
   assign other    = sel_core ? gnt_host : gnt_core;

   // last owner goes straight through when the other side is quiet
   assign pass = active | (own_cyc & ~oth_cyc);

   always_ff @(posedge clk) begin
      if (rst) begin
         owner  <= gnt_core;
         active <= 1'b0;
      end else if (!active) begin
         if (oth_cyc) begin
            owner  <= other; // costs one cycle
            active <= 1'b1;
         end else if (own_cyc) begin
            active <= 1'b1;
         end
      end else if (!own_cyc) begin
         active <= 1'b0;
      end
   end

   assign ram.cyc   = pass & own_cyc;
   assign ram.stb   = pass & (sel_core ? core.stb : host.stb);
   assign ram.we    = sel_core ? core.we : host.we;
   assign ram.adr   = sel_core ? core.adr : host.adr;
   assign ram.dat_w = sel_core ? core.dat_w : host.dat_w;

   assign core.dat_r = ram.dat_r;
   assign host.dat_r = ram.dat_r;
   assign core.ack   = ram.ack & pass & sel_core;
   assign host.ack   = ram.ack & pass & ~sel_core;

endmodule

`default_nettype wire

//--- design/core/cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core (
   input  logic clk,
   input  logic rst,
   input  logic start,
   output logic halted,
   wb_if.master bus
);
   import cpu_pkg::*;
   import bus_pkg::*;

   core_state_e state;

   logic [adr_width-1:0]          pc;
   logic [data_width-1:0]         ir;
   logic [flag_width-1:0]         flags;
   logic [data_width-1:0]         regs [reg_count];

   alu_op_e                       op;
   logic [$clog2(reg_count)-1:0]  rd;
   logic [$clog2(reg_count)-1:0]  rb;
   logic [15:0]                   im;

   logic [data_width-1:0]         alu_res;
   logic [flag_width-1:0]         alu_fo;
   logic                          alu_wb_en;
   logic                          alu_flag_en;

   // op | rd | rb | 2 unused | imm16
   assign op = alu_op_e'(ir[31:26]);
   assign rd = ir[25:22];
   assign rb = ir[21:18];
   assign im = ir[15:0];

   alu alu0 (
      .op      (op),
      .fi      (flags),
      .bi      (regs[rb]),
      .di      (regs[rd]),
      .im      (im),
      .res     (alu_res),
      .fo      (alu_fo),
      .wb_en   (alu_wb_en),
      .flag_en (alu_flag_en)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
         pc    <= '0;
         flags <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (start) begin
                  pc    <= '0;
                  state <= st_fetch;
               end
            end
            st_fetch: begin
               if (bus.ack) begin
                  pc    <= pc + 1'b1;
                  state <= st_exec;
               end
            end
            st_exec: begin
               if (alu_flag_en)
                  flags <= alu_fo;
               case (op)
                  op_ld, op_st: state <= st_mem;
                  op_halt:      state <= st_halted;
                  default:      state <= st_fetch;
               endcase
            end
            st_mem: begin
               if (bus.ack)
                  state <= st_fetch;
            end
            st_halted: ; // left only by rst
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_fetch && bus.ack)
         ir <= bus.dat_r;
      if (state == st_exec && alu_wb_en)
         regs[rd] <= alu_res;
      else if (state == st_mem && bus.ack && op == op_ld)
         regs[rd] <= bus.dat_r;
   end

   // request held for the whole fetch or mem state
   assign bus.cyc   = (state == st_fetch) || (state == st_mem);
   assign bus.stb   = bus.cyc;
   assign bus.we    = (state == st_mem) && (op == op_st);
   assign bus.adr   = (state == st_mem) ? im[adr_width-1:0] : pc;
   assign bus.dat_w = regs[rd];

   assign halted = (state == st_halted);

endmodule

`default_nettype wire

//--- design/alu/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
   input  cpu_pkg::alu_op_e               op,
   input  logic [cpu_pkg::flag_width-1:0] fi,
   input  logic [cpu_pkg::data_width-1:0] bi,
   input  logic [cpu_pkg::data_width-1:0] di,
   input  logic [15:0]                    im,
   output logic [cpu_pkg::data_width-1:0] res,
   output logic [cpu_pkg::flag_width-1:0] fo,
   output logic                           wb_en,
   output logic                           flag_en
);
   import cpu_pkg::*;

   logic [1:0]            op_class;
   logic [data_width-1:0] op2;
   logic [data_width-1:0] b_add;
   logic [data_width:0]   sum;
   logic                  cin;
   logic [data_width-1:0] res_log;
   logic [data_width-1:0] res_sh;
   logic                  c_sh;
   logic                  grp_add;
   logic                  grp_log;
   logic                  grp_sh;

   assign op_class = op[5:4];

   always_comb begin
      op2 = {{16{im[15]}}, im}; // sign extended unless noted
      if (op_class == 2'b00)
         op2 = bi;
      else if (op == op_testi)
         op2 = {16'hffff, im};
      else if (op[3:2] == 2'b00 || op[3:2] == 2'b11)
         op2 = {16'h0000, im};
   end

   always_comb begin
      grp_add = 1'b0;
      grp_log = 1'b0;
      grp_sh  = 1'b0;
      case (op)
         op_add, op_adc, op_sub, op_sbb, op_cmp, op_plus,
         op_addi, op_adci, op_subi, op_sbbi, op_cmpi, op_plusi: grp_add = 1'b1;
         op_btst, op_and, op_or, op_xor, op_test,
         op_btsti, op_andi, op_ori, op_xori, op_testi:          grp_log = 1'b1;
         op_ror, op_rol, op_shl, op_shr, op_sha:                grp_sh  = 1'b1;
         default: ;
      endcase
   end

   // one adder, subtract forms invert op2
   always_comb begin
      cin   = 1'b0;
      b_add = op2;
      case (op)
         op_adc, op_adci: cin = fi[flag_c];
         op_sub, op_subi, op_cmp, op_cmpi: begin
            cin   = 1'b1;
            b_add = ~op2;
         end
         op_sbb, op_sbbi: begin
            cin   = fi[flag_c];
            b_add = ~op2;
         end
         default: ;
      endcase
   end

   assign sum = {1'b0, di} + {1'b0, b_add} + cin;

   always_comb begin
      case (op[3:0])
         4'hd:    res_log = di | op2;
         4'he:    res_log = di ^ op2;
         default: res_log = di & op2; // and, btst, test
      endcase
   end

   always_comb begin
      c_sh = di[0];
      case (op)
         op_ror: res_sh = {fi[flag_c], di[data_width-1:1]};
         op_rol: begin
            res_sh = {di[data_width-2:0], fi[flag_c]};
            c_sh   = di[data_width-1];
         end
         op_shl: begin
            res_sh = {di[data_width-2:0], 1'b0};
            c_sh   = di[data_width-1];
         end
         op_shr:  res_sh = {1'b0, di[data_width-1:1]};
         default: res_sh = {di[data_width-1], di[data_width-1:1]}; // sha
      endcase
   end

   always_comb begin
      res = di;
      case (op)
         op_mov:           res = op2;
         op_movl, op_mvl:  res = {di[31:16], op2[15:0]};
         op_movh, op_mvh:  res = {op2[15:0], di[15:0]};
         op_sed, op_mvs:   res = {{16{op2[15]}}, op2[15:0]};
         op_mvzl:          res = {16'h0000, op2[15:0]};
         op_mul, op_muli:  res = di * op2; // low word only
         op_zeb:           res = {24'h000000, di[7:0]};
         op_zew:           res = {16'h0000, di[15:0]};
         op_seb:           res = {{24{di[7]}}, di[7:0]};
         op_sew:           res = {{16{di[15]}}, di[15:0]};
         op_not:           res = ~di;
         op_neg:           res = -di;
         op_getf:          res = {{(data_width-flag_width){1'b0}}, fi};
         default: ;
      endcase
      if (grp_add)
         res = sum[data_width-1:0];
      else if (grp_log)
         res = res_log;
      else if (grp_sh)
         res = res_sh;
   end

   assign flag_en = grp_add | grp_log | grp_sh;

   always_comb begin
      fo = fi; // logic ops keep c and v
      if (flag_en) begin
         fo[flag_z] = ~|res;
         fo[flag_s] = res[data_width-1];
      end
      if (grp_add) begin
         fo[flag_c] = sum[data_width];
         fo[flag_v] = (di[data_width-1] == b_add[data_width-1]) &
                      (sum[data_width-1] != di[data_width-1]);
      end else if (grp_sh) begin
         fo[flag_c] = c_sh;
         fo[flag_v] = res_sh[data_width-1] ^ di[data_width-1]; // sign changed
      end
   end

   always_comb begin
      case (op)
         op_cmp, op_cmpi, op_btst, op_btsti, op_test, op_testi: wb_en = 1'b0;
         default: wb_en = (op_class != 2'b11);
      endcase
   end

endmodule

`default_nettype wire

//--- common/wb_if.sv
`timescale 1ns/100ps
`default_nettype none

interface wb_if;
   import cpu_pkg::*;
   import bus_pkg::*;

   logic                  cyc;
   logic                  stb;
   logic                  we;
   logic [adr_width-1:0]  adr;
   logic [data_width-1:0] dat_w; // master to slave
   logic [data_width-1:0] dat_r; // slave to master
   logic                  ack;

   modport master (
      output cyc, stb, we, adr, dat_w,
      input  dat_r, ack
   );

   modport slave (
      input  cyc, stb, we, adr, dat_w,
      output dat_r, ack
   );

endinterface

`default_nettype wire

//--- common/bus_pkg.sv
`default_nettype none

package bus_pkg;

   localparam int adr_width = 8; // word address
   localparam int ram_depth = 256;

   // last owner of the RAM port
   typedef enum logic {
      gnt_core,
      gnt_host
   } grant_e;

endpackage

`default_nettype wire

//--- common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

   localparam int data_width = 32;
   localparam int reg_count  = 16;
   localparam int flag_width = 8;

   // bit positions in the flag byte, upper nibble unused
   localparam int flag_c = 0;
   localparam int flag_v = 1;
   localparam int flag_z = 2;
   localparam int flag_s = 3;

   // op[5:4] is the class: 00 two-reg, 01 immediate, 10 single, 11 control
   typedef enum logic [5:0] {
      op_mov   = 6'h00, op_movl  = 6'h01, op_movh  = 6'h02, op_sed   = 6'h03,
      op_add   = 6'h04, op_adc   = 6'h05, op_sub   = 6'h06, op_sbb   = 6'h07,
      op_cmp   = 6'h08, op_mul   = 6'h09, op_plus  = 6'h0a, op_btst  = 6'h0b,
      op_and   = 6'h0c, op_or    = 6'h0d, op_xor   = 6'h0e, op_test  = 6'h0f,
      op_mvl   = 6'h10, op_mvh   = 6'h11, op_mvzl  = 6'h12, op_mvs   = 6'h13,
      op_addi  = 6'h14, op_adci  = 6'h15, op_subi  = 6'h16, op_sbbi  = 6'h17,
      op_cmpi  = 6'h18, op_muli  = 6'h19, op_plusi = 6'h1a, op_btsti = 6'h1b,
      op_andi  = 6'h1c, op_ori   = 6'h1d, op_xori  = 6'h1e, op_testi = 6'h1f,
      op_zeb   = 6'h20, op_zew   = 6'h21, op_seb   = 6'h22, op_sew   = 6'h23,
      op_not   = 6'h24, op_neg   = 6'h25, op_ror   = 6'h26, op_rol   = 6'h27,
      op_shl   = 6'h28, op_shr   = 6'h29, op_sha   = 6'h2a, op_getf  = 6'h2e,
      op_ld    = 6'h30, op_st    = 6'h31, op_halt  = 6'h32
   } alu_op_e;

   typedef enum logic [2:0] {
      st_idle,
      st_fetch,
      st_exec,
      st_mem,
      st_halted
   } core_state_e;

endpackage

`default_nettype wire
